// ==== filelist.f ====
logic/sparseMacPkg.sv
logic/maskAccumulator.sv
logic/compactionFilter.sv
logic/windowMaskFilter.sv
logic/clusterBufferUpdate.sv
logic/sparseMacTop.sv
test/tbClock.sv
test/sparseMacTb.sv

// ==== Makefile ====
# Verilator build and run of the sparse MAC front end testbench

VERILATOR ?= verilator
TOP ?= sparseMacTb
BUILD_DIR ?= build
LOG ?= $(BUILD_DIR)/sim.log
FILELIST ?= filelist.f
VFLAGS ?= --binary --timing -j 0

SOURCES := $(wildcard logic/*.sv) $(wildcard test/*.sv)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@mkdir -p $(BUILD_DIR)
	@./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR)

// ==== test/sparseMacTb.sv ====
`default_nettype none

module sparseMacTb;

	import sparseMacPkg::*;

	// Longest test is the random buffer stream at about 300 cycles
	localparam int CYCLE_LIMIT = 2000;

	logic clock;
	logic reset;
	maskRequest_t maskIn;
	blockRequest_t blockIn;
	maskResult_t maskOut;
	macResult_t macOut;

	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	int cycleCount = 0;
	int modelMacCount = 0;
	int seenMacCount = 0;

	// Clusters selected so far and not yet part of a MAC block
	cluster_t pending[$];

	tbClock #(
		.PERIOD(8),
		.RESET_CYCLES(3)
	) tbClock_i (
		.clock(clock),
		.reset(reset)
	);

	sparseMacTop sparseMacTop_i (
		.clock(clock),
		.reset(reset),
		.maskIn(maskIn),
		.blockIn(blockIn),
		.maskOut(maskOut),
		.macOut(macOut)
	);

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ========================================
	// Reference models
	// ========================================

	// Capped prefix count, then lowest match per slot, then first full pair
	function automatic maskResult_t windowModel(windowMask_t mask, windowIndex_t start);
		maskResult_t expected;
		int counts[WINDOW_SIZE];
		int running;
		logic found;
		expected = '0;
		expected.valid = 1'b1;
		running = 0;
		for (int i = 0; i < WINDOW_SIZE; i++) begin
			if (running == TRANSFER_SIZE) begin
				running = 0;
			end
			if (i >= int'(start) && mask[i]) begin
				running++;
			end
			counts[i] = running;
		end
		for (int k = 0; k < TRANSFER_SIZE; k++) begin
			found = 1'b0;
			for (int i = 0; i < WINDOW_SIZE; i++) begin
				if (!found && counts[i] == k + 1) begin
					expected.denseMask[k] = mask[i];
					found = 1'b1;
				end
			end
		end
		expected.nextStart = windowPos_t'(WINDOW_SIZE);
		found = 1'b0;
		for (int i = 0; i < WINDOW_SIZE; i++) begin
			if (!found && counts[i] == TRANSFER_SIZE) begin
				expected.nextStart = windowPos_t'(i + 1);
				found = 1'b1;
			end
		end
		return expected;
	endfunction

	// ========================================
	// Compare tasks
	// ========================================

	task automatic checkMask(input maskResult_t actual, input maskResult_t expected);
		if (expected.valid && actual.valid !== 1'b1) begin
			$display("No window result on maskOut at time %0t", $time);
			errorCount++;
		end else if (!expected.valid && actual.valid !== 1'b0) begin
			$display("maskOut.valid high with no request one cycle earlier at %0t", $time);
			errorCount++;
		end else if (expected.valid) begin
			if (actual.denseMask !== expected.denseMask) begin
				$display("Mismatch maskOut.denseMask: got 0x%h, expected 0x%h",
					actual.denseMask, expected.denseMask);
				errorCount++;
			end
			if (actual.nextStart !== expected.nextStart) begin
				$display("Mismatch maskOut.nextStart: got 0x%h, expected 0x%h",
					actual.nextStart, expected.nextStart);
				errorCount++;
			end
		end
	endtask

	task automatic checkMac(input macResult_t actual, input macResult_t expected);
		if (expected.valid && actual.valid !== 1'b1) begin
			$display("No MAC block on macOut where one was due at time %0t", $time);
			errorCount++;
		end else if (!expected.valid && actual.valid !== 1'b0) begin
			$display("macOut.valid high with no MAC block due at time %0t", $time);
			errorCount++;
		end else if (expected.valid && actual.clusters !== expected.clusters) begin
			$display("Mismatch macOut.clusters: got 0x%h, expected 0x%h",
				actual.clusters, expected.clusters);
			errorCount++;
		end
	endtask

	// ========================================
	// Drivers
	// ========================================

	// One request on the falling edge, result checked on the next one
	task automatic applyWindow(input windowMask_t mask, input windowIndex_t start);
		maskResult_t expected;
		expected = windowModel(mask, start);
		maskIn.valid = 1'b1;
		maskIn.mutualMask = mask;
		maskIn.startIndex = start;
		@(negedge clock);
		maskIn.valid = 1'b0;
		checkMask(maskOut, expected);
	endtask

	task automatic applyBlock(input logic strobe, input selectMask_t sel,
		input clusterBlock_t data);
		macResult_t expected;
		expected = '0;
		blockIn.valid = strobe;
		blockIn.selectMask = sel;
		blockIn.clusters = data;
		if (strobe) begin
			for (int k = 0; k < TRANSFER_SIZE; k++) begin
				if (sel[k]) begin
					pending.push_back(data[k]);
				end
			end
			if (pending.size() >= TRANSFER_SIZE) begin
				expected.valid = 1'b1;
				for (int k = 0; k < TRANSFER_SIZE; k++) begin
					expected.clusters[k] = pending.pop_front();
				end
				modelMacCount++;
			end
		end
		@(negedge clock);
		blockIn.valid = 1'b0;
		if (macOut.valid === 1'b1) begin
			seenMacCount++;
		end
		checkMac(macOut, expected);
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("%s: clean", name);
		end else begin
			failCount++;
			$display("%s: %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	// ========================================
	// Tests
	// ========================================

	// First look is on the falling edge that ends reset
	task automatic resetIdle();
		int errorsBefore;
		errorsBefore = errorCount;
		repeat (6) begin
			checkMask(maskOut, '0);
			checkMac(macOut, '0);
			@(negedge clock);
		end
		finishTest("reset state", errorsBefore);
	endtask

	task automatic windowDirected();
		int errorsBefore;
		errorsBefore = errorCount;
		applyWindow(32'h0000_0000, 5'd0);
		applyWindow(32'h0000_0010, 5'd0);
		applyWindow(32'h0000_0110, 5'd0);
		applyWindow(32'hF0F0_1234, 5'd0);
		applyWindow(32'h8000_0000, 5'd31);
		applyWindow(32'hFFFF_FFFF, 5'd31);
		applyWindow(32'h0000_00FF, 5'd8);
		applyWindow(32'hA5A5_0000, 5'd17);
		applyWindow(32'h0001_0001, 5'd1);
		finishTest("window directed", errorsBefore);
	endtask

	task automatic windowBackToBack();
		int errorsBefore;
		windowMask_t mask;
		errorsBefore = errorCount;
		for (int n = 0; n < 64; n++) begin
			// Every other mask is made sparse
			mask = $urandom();
			if (n % 2 == 1) begin
				mask = mask & $urandom() & $urandom();
			end
			applyWindow(mask, windowIndex_t'($urandom_range(0, WINDOW_SIZE - 1)));
		end
		@(negedge clock);
		checkMask(maskOut, '0);
		finishTest("window back to back", errorsBefore);
	endtask

	task automatic bufferDirected();
		int errorsBefore;
		errorsBefore = errorCount;
		applyBlock(1'b1, 2'b01, {16'h1102, 16'h1101});
		applyBlock(1'b1, 2'b10, {16'h2202, 16'h2201});
		applyBlock(1'b1, 2'b11, {16'h3302, 16'h3301});
		applyBlock(1'b1, 2'b00, {16'h4402, 16'h4401});
		applyBlock(1'b1, 2'b11, {16'h5502, 16'h5501});
		applyBlock(1'b0, 2'b00, '0);
		finishTest("buffer directed", errorsBefore);
	endtask

	task automatic bufferRandomStream();
		int errorsBefore;
		int modelBefore;
		int seenBefore;
		int gap;
		errorsBefore = errorCount;
		modelBefore = modelMacCount;
		seenBefore = seenMacCount;
		for (int n = 0; n < 100; n++) begin
			applyBlock(1'b1, selectMask_t'($urandom_range(0, 3)), clusterBlock_t'($urandom()));
			gap = int'($urandom_range(0, 2));
			repeat (gap) applyBlock(1'b0, 2'b00, '0);
		end
		// A held cluster must lead the block formed with one more cluster
		if (pending.size() != 0) begin
			applyBlock(1'b1, 2'b01, clusterBlock_t'($urandom()));
		end
		if (seenMacCount - seenBefore != modelMacCount - modelBefore) begin
			$display("MAC block count differs: DUT gave %0d, model expected %0d",
				seenMacCount - seenBefore, modelMacCount - modelBefore);
			errorCount++;
		end
		finishTest("buffer random", errorsBefore);
	endtask

	initial begin
		void'($urandom(52934));
		// Strobes held through reset must leave no result behind
		maskIn = '0;
		maskIn.valid = 1'b1;
		maskIn.mutualMask = 32'h0000_0003;
		blockIn = '0;
		blockIn.valid = 1'b1;
		blockIn.selectMask = 2'b11;
		wait (reset == 1'b0);
		maskIn = '0;
		blockIn = '0;
		resetIdle();
		windowDirected();
		windowBackToBack();
		bufferDirected();
		bufferRandomStream();
		$display("Tests clean: %0d, tests with errors: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/tbClock.sv ====
`default_nettype none

module tbClock #(
	parameter int PERIOD = 8,
	parameter int RESET_CYCLES = 3
) (
	output logic clock,
	output logic reset
);

	// Reset covers the first rising edges and drops on a falling edge
	initial begin
		clock = 1'b0;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

	always #(PERIOD / 2) clock = ~clock;

endmodule

`default_nettype wire

// ==== logic/sparseMacTop.sv ====
`default_nettype none

module sparseMacTop (
	input wire logic clock,
	input wire logic reset,
	input wire sparseMacPkg::maskRequest_t maskIn,
	input wire sparseMacPkg::blockRequest_t blockIn,
	output sparseMacPkg::maskResult_t maskOut,
	output sparseMacPkg::macResult_t macOut
);

	// ========================================
	// Peer paths
	// ========================================

	// Window path picks the next dense select pair
	windowMaskFilter windowMaskFilter_i (
		.clock(clock),
		.reset(reset),
		.request(maskIn),
		.result(maskOut)
	);

	// Cluster path coalesces selected clusters into MAC blocks
	clusterBufferUpdate clusterBufferUpdate_i (
		.clock(clock),
		.reset(reset),
		.request(blockIn),
		.mac(macOut)
	);

endmodule

`default_nettype wire

// ==== logic/clusterBufferUpdate.sv ====
`default_nettype none

module clusterBufferUpdate (
	input wire logic clock,
	input wire logic reset,
	input wire sparseMacPkg::blockRequest_t request,
	output sparseMacPkg::macResult_t mac
);

	import sparseMacPkg::*;

	count_t [TRANSFER_SIZE-1:0] accumulation;
	clusterBlock_t denseClusters;
	count_t numSelected;

	// Buffered cluster followed by the dense clusters of this block
	cluster_t [TRANSFER_SIZE:0] joined;
	logic [COUNT_WIDTH:0] totalCount;
	logic macReady;

	// Holding buffer of one cluster
	logic bufferFull;
	cluster_t bufferCluster;

	logic macValid;
	clusterBlock_t macClusters;

	// ========================================
	// Block compaction
	// ========================================

	maskAccumulator #(
		.LENGTH(TRANSFER_SIZE)
	) blockAccumulator_i (
		.bitmask(request.selectMask),
		.accumulation(accumulation)
	);

	compactionFilter #(
		.LENGTH(TRANSFER_SIZE),
		.element_t(cluster_t)
	) clusterFilter_i (
		.sparseIn(request.clusters),
		.accumulation(accumulation),
		.denseOut(denseClusters)
	);

	// A block cannot wrap the count, so the last entry is the number selected
	assign numSelected = accumulation[TRANSFER_SIZE-1];

	// ========================================
	// Coalescing
	// ========================================

	// Unfilled dense slots come out zero from the filter
	always_comb begin
		joined = '0;
		if (bufferFull) begin
			joined[0] = bufferCluster;
			joined[TRANSFER_SIZE:1] = denseClusters;
		end else begin
			joined[TRANSFER_SIZE-1:0] = denseClusters;
		end
	end

	assign totalCount = {{COUNT_WIDTH{1'b0}}, bufferFull} + {1'b0, numSelected};
	assign macReady = (totalCount >= (COUNT_WIDTH + 1)'(TRANSFER_SIZE));

	// ========================================
	// State update
	// ========================================

	always_ff @(posedge clock) begin
		if (reset) begin
			macValid <= 1'b0;
			bufferFull <= 1'b0;
		end else begin
			macValid <= request.valid && macReady;
			if (request.valid) begin
				if (macReady) begin
					// Only a third cluster is left over
					bufferFull <= (totalCount > (COUNT_WIDTH + 1)'(TRANSFER_SIZE));
				end else begin
					bufferFull <= (totalCount != '0);
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (request.valid) begin
			if (macReady) begin
				macClusters <= joined[TRANSFER_SIZE-1:0];
				bufferCluster <= joined[TRANSFER_SIZE];
			end else begin
				bufferCluster <= joined[0];
			end
		end
	end

	assign mac = '{valid: macValid, clusters: macClusters};

endmodule

`default_nettype wire

// ==== logic/windowMaskFilter.sv ====
`default_nettype none

module windowMaskFilter (
	input wire logic clock,
	input wire logic reset,
	input wire sparseMacPkg::maskRequest_t request,
	output sparseMacPkg::maskResult_t result
);

	import sparseMacPkg::*;

	windowMask_t keepMask;
	windowMask_t liveMask;
	count_t [WINDOW_SIZE-1:0] accumulation;
	selectMask_t denseMask;
	windowPos_t nextStart;

	logic validReg;
	selectMask_t denseMaskReg;
	windowPos_t nextStartReg;

	// ========================================
	// Window compaction
	// ========================================

	// Drop every position below the start index before counting
	assign keepMask = ~windowMask_t'(0) << request.startIndex;
	assign liveMask = request.mutualMask & keepMask;

	maskAccumulator #(
		.LENGTH(WINDOW_SIZE)
	) windowAccumulator_i (
		.bitmask(liveMask),
		.accumulation(accumulation)
	);

	// Mask bits are single-bit elements here
	compactionFilter #(
		.LENGTH(WINDOW_SIZE),
		.element_t(logic)
	) windowFilter_i (
		.sparseIn(liveMask),
		.accumulation(accumulation),
		.denseOut(denseMask)
	);

	// Following pair starts right after the position that fills the current one
	always_comb begin
		nextStart = windowPos_t'(WINDOW_SIZE);
		for (int i = WINDOW_SIZE - 1; i >= 0; i--) begin
			if (accumulation[i] == count_t'(TRANSFER_SIZE)) begin
				nextStart = windowPos_t'(i + 1);
			end
		end
	end

	// ========================================
	// Result register
	// ========================================

	always_ff @(posedge clock) begin
		if (reset) begin
			validReg <= 1'b0;
		end else begin
			validReg <= request.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (request.valid) begin
			denseMaskReg <= denseMask;
			nextStartReg <= nextStart;
		end
	end

	assign result = '{valid: validReg, denseMask: denseMaskReg, nextStart: nextStartReg};

endmodule

`default_nettype wire

// ==== logic/compactionFilter.sv ====
`default_nettype none

module compactionFilter #(
	parameter int LENGTH = sparseMacPkg::WINDOW_SIZE,
	parameter type element_t = logic
) (
	input wire element_t [LENGTH-1:0] sparseIn,
	input wire sparseMacPkg::count_t [LENGTH-1:0] accumulation,
	output element_t [sparseMacPkg::TRANSFER_SIZE-1:0] denseOut
);

	import sparseMacPkg::*;

	// ========================================
	// Slot search
	// ========================================

	// Slot k is filled from the first position whose running count is k+1
	// Positions after a wrap reuse the same counts, so only the first hit counts
	always_comb begin
		logic found;
		count_t target;
		for (int k = 0; k < TRANSFER_SIZE; k++) begin
			found = 1'b0;
			target = count_t'(k + 1);
			denseOut[k] = '0;
			for (int i = 0; i < LENGTH; i++) begin
				if (!found && (accumulation[i] == target)) begin
					denseOut[k] = sparseIn[i];
					found = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/maskAccumulator.sv ====
`default_nettype none

module maskAccumulator #(
	parameter int LENGTH = sparseMacPkg::WINDOW_SIZE
) (
	input wire logic [LENGTH-1:0] bitmask,
	output sparseMacPkg::count_t [LENGTH-1:0] accumulation
);

	import sparseMacPkg::*;

	// One step of the capped count
	// A count that already sits at the cap starts over before the new bit is added
	function automatic count_t stepCount(count_t previous, logic bitIn);
		count_t base;
		if (previous == count_t'(TRANSFER_SIZE)) begin
			base = '0;
		end else begin
			base = previous;
		end
		return base + count_t'(bitIn);
	endfunction

	// ========================================
	// Prefix chain
	// ========================================

	// Bit 0 is counted first, so entry i already includes bitmask[i]
	always_comb begin
		count_t running;
		running = '0;
		for (int i = 0; i < LENGTH; i++) begin
			running = stepCount(running, bitmask[i]);
			accumulation[i] = running;
		end
	end

endmodule

`default_nettype wire

// ==== logic/sparseMacPkg.sv ====
`default_nettype none

package sparseMacPkg;

	// ========================================
	// Sizes
	// ========================================

	// Clusters per transfer block and per MAC block
	localparam int TRANSFER_SIZE = 2;

	// Positions in one compression window
	localparam int WINDOW_SIZE = 32;

	localparam int CLUSTER_WIDTH = 16;

	// Holds every count from 0 up to TRANSFER_SIZE
	localparam int COUNT_WIDTH = 2;

	localparam int INDEX_WIDTH = 5;

	// ========================================
	// Element types
	// ========================================

	typedef logic [CLUSTER_WIDTH-1:0] cluster_t;
	typedef logic [COUNT_WIDTH-1:0] count_t;
	typedef logic [INDEX_WIDTH-1:0] windowIndex_t;

	// One bit wider so that WINDOW_SIZE itself marks an exhausted window
	typedef logic [INDEX_WIDTH:0] windowPos_t;

	typedef logic [WINDOW_SIZE-1:0] windowMask_t;
	typedef logic [TRANSFER_SIZE-1:0] selectMask_t;

	// Element 0 sits in the low bits
	typedef cluster_t [TRANSFER_SIZE-1:0] clusterBlock_t;

	// ========================================
	// Requests and results
	// ========================================

	typedef struct packed {
		logic valid;
		windowMask_t mutualMask;
		windowIndex_t startIndex;
	} maskRequest_t;

	typedef struct packed {
		logic valid;
		selectMask_t denseMask;
		windowPos_t nextStart;
	} maskResult_t;

	typedef struct packed {
		logic valid;
		selectMask_t selectMask;
		clusterBlock_t clusters;
	} blockRequest_t;

	typedef struct packed {
		logic valid;
		clusterBlock_t clusters;
	} macResult_t;

endpackage

`default_nettype wire
